//--- sources.f
hw/core_pkg.sv
hw/byte_stream_if.sv
hw/prefetch.sv
hw/prefetch_fifo.sv
hw/exec_unit.sv
hw/core.sv
bench/tb_mem.sv
bench/tb_core.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal
TOP ?= tb_core
BUILD_DIR ?= obj_dir
FILE_LIST ?= sources.f
PASS_TEXT ?= TB PASSED

SRCS := $(shell cat $(FILE_LIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;

    localparam int FIFO_DEPTH = 6;
    // Sum of the program bytes of all runs below
    localparam int PROG_BYTES = 136;
    localparam int CYCLE_LIMIT = 8 * PROG_BYTES * 6 + 200;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic rand_en = 1'b0;
    logic [15:1] instr_addr;
    logic [15:0] instr_data_in;
    logic instr_access;
    logic instr_ack;
    logic [15:1] data_addr;
    logic [15:0] data_data_in;
    logic [15:0] data_data_out;
    logic data_access;
    logic data_ack;
    logic data_wr_en;
    logic halted;

    logic [7:0] prog [512];
    int prog_len;
    int cycles = 0;
    bit halt_seen = 1'b0;
    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];

    core #(.FIFO_DEPTH(FIFO_DEPTH), .RESET_IP(16'h0000)) DUT (
        .clk(clk), .reset(reset),
        .instr_addr(instr_addr), .instr_data_in(instr_data_in),
        .instr_access(instr_access), .instr_ack(instr_ack),
        .data_addr(data_addr), .data_data_in(data_data_in),
        .data_data_out(data_data_out), .data_access(data_access),
        .data_ack(data_ack), .data_wr_en(data_wr_en), .halted(halted)
    );

    tb_mem u_mem (
        .clk(clk), .reset(reset), .rand_en(rand_en),
        .instr_addr(instr_addr), .instr_data_in(instr_data_in),
        .instr_access(instr_access), .instr_ack(instr_ack),
        .data_addr(data_addr), .data_data_in(data_data_in),
        .data_data_out(data_data_out), .data_access(data_access),
        .data_ack(data_ack), .data_wr_en(data_wr_en)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the core did not finish the programs in time");
            $display("TB FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    always @(negedge clk) begin
        if (!reset && instr_access) begin
            assert (int'(instr_addr) * 2 < prog_len + FIFO_DEPTH + 2) else begin
                $display("Instruction fetch left the program area at %0t", $time);
                $display("TB FAILED");
                $fatal(1, "fetch out of range");
            end
        end
        if (halt_seen) begin
            assert (halted && !data_access) else begin
                $display("Core left halt or used the data bus after halting at %0t", $time);
                $display("TB FAILED");
                $fatal(1, "activity after halt");
            end
        end
    end

    task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic begin_program();
        prog_len = 0;
        for (int i = 0; i < 512; i++)
            prog[i] = {core_pkg::OP_HALT, 3'd7};
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 256; i++)
            u_mem.ram[i] = {i[7:0], ~i[7:0]};
    endtask

    task automatic emit(input logic [7:0] b);
        prog[prog_len] = b;
        prog_len++;
    endtask

    task automatic emit_imm(input logic [4:0] op, input logic [2:0] r, input logic [15:0] imm);
        emit({op, r});
        emit(imm[7:0]);
        emit(imm[15:8]);
    endtask

    task automatic expect_write(input logic [15:0] addr, input logic [15:0] value);
        exp_addr.push_back(addr);
        exp_data.push_back(value);
    endtask

    task automatic run_program(input bit rnd);
        for (int i = 0; i < 256; i++)
            u_mem.rom[i] = {prog[2 * i + 1], prog[2 * i]};
        rand_en = rnd;
        reset = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        while (!halted)
            @(negedge clk);
        halt_seen = 1'b1;
        repeat (20) @(negedge clk);
        halt_seen = 1'b0;
        check_eq("write count", 16'(u_mem.log_count), 16'(exp_addr.size()));
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_eq("data_addr", u_mem.log_addr[i], exp_addr[i]);
            check_eq("data_data_out", u_mem.log_data[i], exp_data[i]);
        end
    endtask

    task automatic movi_then_store();
        begin_program();
        emit_imm(core_pkg::OP_MOVI, 3'd1, 16'h1234);
        emit_imm(core_pkg::OP_STORE, 3'd1, 16'h0040);
        emit_imm(core_pkg::OP_MOVI, 3'd2, 16'hBEEF);
        emit_imm(core_pkg::OP_STORE, 3'd2, 16'h0042);
        emit({core_pkg::OP_HALT, 3'd0});
        expect_write(16'h0040, 16'h1234);
        expect_write(16'h0042, 16'hBEEF);
        run_program(1'b1);
    endtask

    task automatic add_and_wrap();
        begin_program();
        emit_imm(core_pkg::OP_MOVI, 3'd0, 16'hFFF0);
        emit_imm(core_pkg::OP_MOVI, 3'd1, 16'h0025);
        emit({core_pkg::OP_ADD, 3'd0});
        emit(8'd1);
        emit_imm(core_pkg::OP_STORE, 3'd0, 16'h0050);
        emit_imm(core_pkg::OP_MOVI, 3'd2, 16'd100);
        emit_imm(core_pkg::OP_MOVI, 3'd3, 16'd23);
        emit({core_pkg::OP_ADD, 3'd2});
        emit(8'd3);
        emit_imm(core_pkg::OP_STORE, 3'd2, 16'h0052);
        emit({core_pkg::OP_HALT, 3'd0});
        // FFF0 plus 0025 wraps past 16'hFFFF
        expect_write(16'h0050, 16'h0015);
        expect_write(16'h0052, 16'd123);
        run_program(1'b1);
    endtask

    task automatic copy_loaded_words();
        begin_program();
        u_mem.ram[8'h30] = 16'hCAFE;
        u_mem.ram[8'h31] = 16'h0102;
        emit_imm(core_pkg::OP_LOAD, 3'd4, 16'h0060);
        emit_imm(core_pkg::OP_LOAD, 3'd5, 16'h0062);
        emit_imm(core_pkg::OP_STORE, 3'd4, 16'h0070);
        emit_imm(core_pkg::OP_STORE, 3'd5, 16'h0072);
        emit({core_pkg::OP_HALT, 3'd0});
        expect_write(16'h0070, 16'hCAFE);
        expect_write(16'h0072, 16'h0102);
        run_program(1'b1);
    endtask

    task automatic jump_to_odd_address();
        begin_program();
        emit_imm(core_pkg::OP_MOVI, 3'd1, 16'h1111);
        emit_imm(core_pkg::OP_JMP, 3'd0, 16'h0009);
        // Skipped store at bytes 6 to 8
        emit_imm(core_pkg::OP_STORE, 3'd1, 16'h0080);
        emit_imm(core_pkg::OP_STORE, 3'd1, 16'h0082);
        emit({core_pkg::OP_HALT, 3'd0});
        expect_write(16'h0082, 16'h1111);
        run_program(1'b1);
    endtask

    task automatic long_program(input bit rnd);
        begin_program();
        emit_imm(core_pkg::OP_MOVI, 3'd0, 16'd1000);
        emit_imm(core_pkg::OP_MOVI, 3'd1, 16'h8001);
        emit_imm(core_pkg::OP_MOVI, 3'd2, 16'h7FFF);
        emit_imm(core_pkg::OP_MOVI, 3'd3, 16'd5);
        emit({core_pkg::OP_ADD, 3'd0});
        emit(8'd1);
        emit({core_pkg::OP_ADD, 3'd1});
        emit(8'd2);
        emit({core_pkg::OP_ADD, 3'd3});
        emit(8'd0);
        emit_imm(core_pkg::OP_STORE, 3'd0, 16'h0090);
        emit_imm(core_pkg::OP_STORE, 3'd1, 16'h0092);
        emit_imm(core_pkg::OP_STORE, 3'd2, 16'h0094);
        emit_imm(core_pkg::OP_STORE, 3'd3, 16'h0096);
        emit({core_pkg::OP_HALT, 3'd0});
        // 03E8 plus 8001, then 8001 plus 7FFF wrapping to zero
        expect_write(16'h0090, 16'h83E9);
        expect_write(16'h0092, 16'h0000);
        expect_write(16'h0094, 16'h7FFF);
        expect_write(16'h0096, 16'h83EE);
        run_program(rnd);
    endtask

    task automatic unknown_opcode_then_halt();
        begin_program();
        emit_imm(core_pkg::OP_MOVI, 3'd6, 16'h5A5A);
        emit(8'h00);
        emit(8'h33);
        emit_imm(core_pkg::OP_STORE, 3'd6, 16'h00A0);
        emit({core_pkg::OP_HALT, 3'd0});
        emit_imm(core_pkg::OP_STORE, 3'd6, 16'h00A2);
        expect_write(16'h00A0, 16'h5A5A);
        run_program(1'b1);
    endtask

    initial begin
        movi_then_store();
        add_and_wrap();
        copy_loaded_words();
        jump_to_odd_address();
        long_program(1'b0);
        long_program(1'b1);
        unknown_opcode_then_halt();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/tb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem (
    input wire clk,
    input wire reset,
    input wire rand_en,
    input wire [15:1] instr_addr,
    output logic [15:0] instr_data_in,
    input wire instr_access,
    output logic instr_ack,
    input wire [15:1] data_addr,
    output logic [15:0] data_data_in,
    input wire [15:0] data_data_out,
    input wire data_access,
    output logic data_ack,
    input wire data_wr_en
);

    logic [15:0] rom [256];
    logic [15:0] ram [256];
    logic [15:0] log_addr [64];
    logic [15:0] log_data [64];
    int log_count;
    int instr_wait;
    int data_wait;
    integer seed = 32'hd046f64a;

    assign instr_data_in = rom[instr_addr[8:1]];
    assign data_data_in = ram[data_addr[8:1]];

    function automatic int draw_delay();
        if (!rand_en)
            return 0;
        return int'($unsigned($random(seed)) % 4);
    endfunction

    initial begin
        instr_ack = 1'b0;
        data_ack = 1'b0;
        log_count = 0;
    end

    // One-cycle ack and a fresh delay for every access
    always @(negedge clk) begin
        if (reset) begin
            instr_ack = 1'b0;
            instr_wait = draw_delay();
        end else if (instr_ack) begin
            instr_ack = 1'b0;
            instr_wait = draw_delay();
        end else if (instr_access) begin
            if (instr_wait == 0)
                instr_ack = 1'b1;
            else
                instr_wait = instr_wait - 1;
        end
    end

    always @(negedge clk) begin
        if (reset) begin
            data_ack = 1'b0;
            data_wait = draw_delay();
            log_count = 0;
        end else if (data_ack) begin
            data_ack = 1'b0;
            data_wait = draw_delay();
        end else if (data_access) begin
            if (data_wait == 0) begin
                data_ack = 1'b1;
                if (data_wr_en) begin
                    ram[data_addr[8:1]] = data_data_out;
                    log_addr[log_count] = {data_addr, 1'b0};
                    log_data[log_count] = data_data_out;
                    log_count = log_count + 1;
                end
            end else begin
                data_wait = data_wait - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/core.sv
`timescale 1ns/1ps
`default_nettype none

module core #(
    parameter int FIFO_DEPTH = 6,
    parameter logic [core_pkg::WORD_W-1:0] RESET_IP = '0
) (
    input wire clk,
    input wire reset,
    // Instruction bus
    output logic [core_pkg::WORD_W-1:1] instr_addr,
    input wire [core_pkg::WORD_W-1:0] instr_data_in,
    output logic instr_access,
    input wire instr_ack,
    // Data bus
    output logic [core_pkg::WORD_W-1:1] data_addr,
    input wire [core_pkg::WORD_W-1:0] data_data_in,
    output logic [core_pkg::WORD_W-1:0] data_data_out,
    output logic data_access,
    input wire data_ack,
    output logic data_wr_en,
    output logic halted
);

    logic load_ip;
    logic [core_pkg::WORD_W-1:0] new_ip;

    byte_stream_if fifo_bus ();

    prefetch #(
        .RESET_IP(RESET_IP)
    ) u_prefetch (
        .clk(clk),
        .reset(reset),
        .fifo(fifo_bus.fetch),
        .load_ip(load_ip),
        .new_ip(new_ip),
        .mem_addr(instr_addr),
        .mem_data(instr_data_in),
        .mem_access(instr_access),
        .mem_ack(instr_ack)
    );

    prefetch_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_prefetch_fifo (
        .clk(clk),
        .reset(reset),
        .fifo(fifo_bus.buffer)
    );

    exec_unit u_exec_unit (
        .clk(clk),
        .reset(reset),
        .fifo(fifo_bus.decode),
        .load_ip(load_ip),
        .new_ip(new_ip),
        .mem_addr(data_addr),
        .mem_data_in(data_data_in),
        .mem_data_out(data_data_out),
        .mem_access(data_access),
        .mem_ack(data_ack),
        .mem_wr_en(data_wr_en),
        .halted(halted)
    );

endmodule

`default_nettype wire

//--- hw/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input wire clk,
    input wire reset,
    byte_stream_if.decode fifo,
    output logic load_ip,
    output logic [core_pkg::WORD_W-1:0] new_ip,
    output logic [core_pkg::WORD_W-1:1] mem_addr,
    input wire [core_pkg::WORD_W-1:0] mem_data_in,
    output logic [core_pkg::WORD_W-1:0] mem_data_out,
    output logic mem_access,
    input wire mem_ack,
    output logic mem_wr_en,
    output logic halted
);

    localparam int NUM_REGS = 2 ** core_pkg::REG_IDX_W;

    core_pkg::exec_state_t state;
    core_pkg::opcode_t opcode;
    core_pkg::opcode_t byte_op;
    logic [core_pkg::REG_IDX_W-1:0] dst;
    logic [core_pkg::REG_IDX_W-1:0] src;
    logic [core_pkg::WORD_W-1:0] imm;
    logic [core_pkg::WORD_W-1:0] regs [NUM_REGS];
    logic take;
    logic jump;

    assign byte_op = core_pkg::opcode_t'(fifo.rd_data[7:3]);

    // One byte per cycle while in a fetch state
    assign fifo.rd_en = (state == core_pkg::EX_OPCODE) ||
                        (state == core_pkg::EX_REG2) ||
                        (state == core_pkg::EX_IMM_LO) ||
                        (state == core_pkg::EX_IMM_HI);
    assign take = fifo.rd_en && !fifo.empty;

    assign jump = (state == core_pkg::EX_EXECUTE) && (opcode == core_pkg::OP_JMP);
    assign fifo.flush = jump;
    assign load_ip = jump;
    assign new_ip = imm;

    assign mem_addr = imm[core_pkg::WORD_W-1:1];
    assign mem_data_out = regs[dst];
    assign mem_access = (state == core_pkg::EX_MEM_WAIT);
    assign mem_wr_en = mem_access && (opcode == core_pkg::OP_STORE);
    assign halted = (state == core_pkg::EX_HALTED);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_pkg::EX_OPCODE;
            opcode <= core_pkg::OP_HALT;
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            case (state)
                core_pkg::EX_OPCODE: begin
                    if (take) begin
                        opcode <= byte_op;
                        case (byte_op)
                            core_pkg::OP_ADD: state <= core_pkg::EX_REG2;
                            core_pkg::OP_MOVI,
                            core_pkg::OP_LOAD,
                            core_pkg::OP_STORE,
                            core_pkg::OP_JMP: state <= core_pkg::EX_IMM_LO;
                            core_pkg::OP_HALT: state <= core_pkg::EX_HALTED;
                            // Unknown opcode acts as a one-byte no-op
                            default: state <= core_pkg::EX_OPCODE;
                        endcase
                    end
                end
                core_pkg::EX_REG2: begin
                    if (take) begin
                        state <= core_pkg::EX_EXECUTE;
                    end
                end
                core_pkg::EX_IMM_LO: begin
                    if (take) begin
                        state <= core_pkg::EX_IMM_HI;
                    end
                end
                core_pkg::EX_IMM_HI: begin
                    if (take) begin
                        state <= core_pkg::EX_EXECUTE;
                    end
                end
                core_pkg::EX_EXECUTE: begin
                    case (opcode)
                        core_pkg::OP_MOVI: begin
                            regs[dst] <= imm;
                            state <= core_pkg::EX_OPCODE;
                        end
                        core_pkg::OP_ADD: begin
                            regs[dst] <= regs[dst] + regs[src];
                            state <= core_pkg::EX_OPCODE;
                        end
                        core_pkg::OP_LOAD,
                        core_pkg::OP_STORE: state <= core_pkg::EX_MEM_WAIT;
                        default: state <= core_pkg::EX_OPCODE;
                    endcase
                end
                core_pkg::EX_MEM_WAIT: begin
                    if (mem_ack) begin
                        if (opcode == core_pkg::OP_LOAD) begin
                            regs[dst] <= mem_data_in;
                        end
                        state <= core_pkg::EX_OPCODE;
                    end
                end
                core_pkg::EX_HALTED: state <= core_pkg::EX_HALTED;
                default: state <= core_pkg::EX_OPCODE;
            endcase
        end
    end

    // Operand capture as bytes leave the FIFO
    always_ff @(posedge clk) begin
        if (take) begin
            case (state)
                core_pkg::EX_OPCODE: dst <= fifo.rd_data[core_pkg::REG_IDX_W-1:0];
                core_pkg::EX_REG2: src <= fifo.rd_data[core_pkg::REG_IDX_W-1:0];
                core_pkg::EX_IMM_LO: imm[7:0] <= fifo.rd_data;
                core_pkg::EX_IMM_HI: imm[15:8] <= fifo.rd_data;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/prefetch_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module prefetch_fifo #(
    parameter int FIFO_DEPTH = 6
) (
    input wire clk,
    input wire reset,
    byte_stream_if.buffer fifo
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);

    logic [core_pkg::BYTE_W-1:0] mem [FIFO_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic do_wr;
    logic do_rd;

    assign fifo.empty = (count == '0);
    assign fifo.nearly_full = (count >= CNT_W'(FIFO_DEPTH - 1));
    // Fall-through read port
    assign fifo.rd_data = mem[rd_ptr];

    assign do_wr = fifo.wr_en && (count != CNT_W'(FIFO_DEPTH)) && !fifo.flush;
    assign do_rd = fifo.rd_en && !fifo.empty;

    always_ff @(posedge clk) begin
        if (reset || fifo.flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + PTR_W'(1);
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + PTR_W'(1);
            end
            if (do_wr && !do_rd) begin
                count <= count + CNT_W'(1);
            end else if (do_rd && !do_wr) begin
                count <= count - CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= fifo.wr_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/prefetch.sv
`timescale 1ns/1ps
`default_nettype none

module prefetch #(
    parameter logic [core_pkg::WORD_W-1:0] RESET_IP = '0
) (
    input wire clk,
    input wire reset,
    byte_stream_if.fetch fifo,
    input wire load_ip,
    input wire [core_pkg::WORD_W-1:0] new_ip,
    output logic [core_pkg::WORD_W-1:1] mem_addr,
    input wire [core_pkg::WORD_W-1:0] mem_data,
    output logic mem_access,
    input wire mem_ack
);

    core_pkg::fetch_state_t state;
    logic [core_pkg::WORD_W-1:0] fetch_ip;
    logic [core_pkg::WORD_W-1:0] next_word_ip;
    logic [core_pkg::WORD_W-1:1] access_addr;
    logic [core_pkg::BYTE_W-1:0] hi_byte;

    assign next_word_ip = {access_addr + (core_pkg::WORD_W - 1)'(1), 1'b0};
    assign mem_addr = access_addr;
    // Discard keeps the bus cycle open until the stale ack arrives
    assign mem_access = (state == core_pkg::PF_ACCESS) || (state == core_pkg::PF_DISCARD);

    always_comb begin
        fifo.wr_en = 1'b0;
        fifo.wr_data = hi_byte;
        if (!fifo.flush) begin
            if (state == core_pkg::PF_ACCESS && mem_ack) begin
                fifo.wr_en = 1'b1;
                // Odd pointer skips the low byte
                fifo.wr_data = fetch_ip[0] ? mem_data[15:8] : mem_data[7:0];
            end else if (state == core_pkg::PF_PUSH_HI) begin
                fifo.wr_en = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= core_pkg::PF_IDLE;
            fetch_ip <= RESET_IP;
        end else begin
            case (state)
                core_pkg::PF_IDLE: begin
                    if (load_ip) begin
                        fetch_ip <= new_ip;
                    end else if (!fifo.nearly_full) begin
                        state <= core_pkg::PF_ACCESS;
                    end
                end
                core_pkg::PF_ACCESS: begin
                    if (load_ip) begin
                        fetch_ip <= new_ip;
                        state <= mem_ack ? core_pkg::PF_IDLE : core_pkg::PF_DISCARD;
                    end else if (mem_ack) begin
                        if (fetch_ip[0]) begin
                            fetch_ip <= next_word_ip;
                            state <= core_pkg::PF_IDLE;
                        end else begin
                            state <= core_pkg::PF_PUSH_HI;
                        end
                    end
                end
                core_pkg::PF_PUSH_HI: begin
                    fetch_ip <= load_ip ? new_ip : next_word_ip;
                    state <= core_pkg::PF_IDLE;
                end
                core_pkg::PF_DISCARD: begin
                    if (load_ip) begin
                        fetch_ip <= new_ip;
                    end
                    if (mem_ack) begin
                        state <= core_pkg::PF_IDLE;
                    end
                end
                default: state <= core_pkg::PF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_pkg::PF_IDLE) begin
            access_addr <= fetch_ip[core_pkg::WORD_W-1:1];
        end
        if (state == core_pkg::PF_ACCESS && mem_ack) begin
            hi_byte <= mem_data[15:8];
        end
    end

endmodule

`default_nettype wire

//--- hw/byte_stream_if.sv
`timescale 1ns/1ps
`default_nettype none

interface byte_stream_if;

    logic wr_en;
    logic [core_pkg::BYTE_W-1:0] wr_data;
    logic nearly_full;
    logic rd_en;
    logic [core_pkg::BYTE_W-1:0] rd_data;
    logic empty;
    // Pulsed by the execute unit on a taken jump
    logic flush;

    modport fetch (output wr_en, wr_data, input nearly_full, flush);

    modport buffer (input wr_en, wr_data, rd_en, flush,
                    output rd_data, empty, nearly_full);

    modport decode (output rd_en, flush, input rd_data, empty);

endinterface

`default_nettype wire

//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int WORD_W = 16;
    localparam int BYTE_W = 8;
    localparam int REG_IDX_W = 3;

    // Opcode in the top five bits of a byte and a register index in the low three
    typedef enum logic [4:0] {
        OP_MOVI  = 5'd1,
        OP_ADD   = 5'd2,
        OP_LOAD  = 5'd3,
        OP_STORE = 5'd4,
        OP_JMP   = 5'd5,
        OP_HALT  = 5'd31
    } opcode_t;

    typedef enum logic [2:0] {
        EX_OPCODE,
        EX_REG2,
        EX_IMM_LO,
        EX_IMM_HI,
        EX_EXECUTE,
        EX_MEM_WAIT,
        EX_HALTED
    } exec_state_t;

    typedef enum logic [1:0] {
        PF_IDLE,
        PF_ACCESS,
        PF_PUSH_HI,
        PF_DISCARD
    } fetch_state_t;

endpackage

`default_nettype wire
